/* list.f */
+incdir+hw
hw/cpu_pkg.sv
hw/reg_file.sv
hw/decoder.sv
hw/alu.sv
hw/perf_counters.sv
hw/cpu_control.sv
hw/cpu_top.sv
verif/tb_clock.sv
verif/tb_cpu.sv

/* build.sh */
#!/bin/sh
# compile with Verilator, run, and decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f list.f --top-module tb_cpu -o tb_cpu_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

/* verif/tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int          RESET_CYCLES = 8;
    localparam real         CLK_PERIOD   = 8.0;
    localparam int          MAX_INSTR    = 200;
    localparam int          CYCLES_PER   = 12;
    localparam real         TIMEOUT_NS   = (RESET_CYCLES + MAX_INSTR * CYCLES_PER) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h49a6_ebd4;
    localparam word_t       FIRST_FETCH  = 32'h0000_0000;
    localparam word_t       STORE_ADDR   = 32'h0000_0100;
    localparam word_t       STORE_DATA   = 32'h1234_5678;

    // RV32I base opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_SYSTEM = 7'h73;

    logic     clk;
    logic     rstn;
    logic     imem_req;
    word_t    imem_addr;
    logic     imem_valid;
    word_t    imem_rdata;
    logic     dmem_req;
    logic     dmem_we;
    word_t    dmem_addr;
    word_t    dmem_wdata;
    logic     dmem_valid;
    word_t    dmem_rdata;
    logic     retire;
    word_t    retire_pc;
    logic     retire_rd_we;
    reg_idx_t retire_rd;
    word_t    retire_rd_data;
    logic     halted;

    word_t    imem [64];
    word_t    dmem [256];
    word_t    exp_pc [$];
    logic     exp_we [$];
    reg_idx_t exp_rd [$];
    word_t    exp_val [$];
    logic     exp_cycle [$];
    int       errors = 0;
    int       retired = 0;
    int       fetches = 0;
    int       stores = 0;
    int       loads = 0;
    int       cycle_reads = 0;
    word_t    last_cycle = '0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    cpu_top UUT (
        .clk(clk), .rstn(rstn),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
        .retire(retire), .retire_pc(retire_pc), .retire_rd_we(retire_rd_we),
        .retire_rd(retire_rd), .retire_rd_data(retire_rd_data), .halted(halted)
    );

    function automatic word_t i_format(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t r_format(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3,
                                       input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t s_format(input logic [11:0] imm, input reg_idx_t rs2,
                                       input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_format(input logic [12:0] off, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_format(input logic [19:0] imm, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_format(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %s got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("error: %s at %0t", what, $time);
        end
    endtask

    // instruction that is jumped over and never retires
    task automatic place_skipped(input word_t pc, input word_t instr);
        imem[pc[7:2]] = instr;
    endtask

    task automatic place_step(input word_t pc, input word_t instr, input logic we,
                              input reg_idx_t rd, input word_t val, input logic is_cycle);
        imem[pc[7:2]] = instr;
        exp_pc.push_back(pc);
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
        exp_cycle.push_back(is_cycle);
    endtask

    task automatic fill_memories();
        // opcode 7f is illegal, upper bits carry the word index
        for (int i = 0; i < 64; i++) begin
            imem[i] = (word_t'(i) << 7) | 32'h0000_007f;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = ~(word_t'(i) << 2);
        end
    endtask

    task automatic build_program();
        place_step(0,  i_format(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 1'b1, 5'd1, 32'd5, 1'b0);
        place_step(4,  i_format(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 1'b1, 5'd2,
                   32'hffff_fffd, 1'b0);
        place_step(8,  r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'd2, 1'b0);
        place_step(12, r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'd8, 1'b0);
        // sra x5, x2, x1: -3 >>> 5
        place_step(16, r_format(7'h20, 5'd1, 5'd2, 3'b101, 5'd5), 1'b1, 5'd5,
                   32'hffff_ffff, 1'b0);
        place_step(20, r_format(7'h00, 5'd2, 5'd1, 3'b011, 5'd6), 1'b1, 5'd6, 32'd1, 1'b0);
        place_step(24, u_format(20'h12345, 5'd7, OPC_LUI), 1'b1, 5'd7, 32'h1234_5000, 1'b0);
        // write to x0 must not show up
        place_step(28, i_format(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0, 5'd0, '0, 1'b0);
        place_step(32, i_format(12'h678, 5'd7, 3'b110, 5'd8, OPC_OP_IMM), 1'b1, 5'd8,
                   STORE_DATA, 1'b0);
        place_step(36, s_format(12'h100, 5'd8, 5'd0), 1'b0, 5'd0, '0, 1'b0);
        place_step(40, i_format(12'h100, 5'd0, 3'b010, 5'd9, OPC_LOAD), 1'b1, 5'd9,
                   STORE_DATA, 1'b0);
        place_step(44, b_format(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, 5'd0, '0, 1'b0);
        place_step(48, b_format(13'd8, 5'd2, 5'd1, 3'b001), 1'b0, 5'd0, '0, 1'b0);
        place_skipped(52, i_format(12'd1, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        place_step(56, j_format(21'd8, 5'd11), 1'b1, 5'd11, 32'd60, 1'b0);
        place_skipped(60, i_format(12'd2, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        place_step(64, u_format(20'h0, 5'd12, OPC_AUIPC), 1'b1, 5'd12, 32'd64, 1'b0);
        // odd target 77 lands on 76
        place_step(68, i_format(12'd13, 5'd12, 3'b000, 5'd13, OPC_JALR), 1'b1, 5'd13,
                   32'd72, 1'b0);
        place_skipped(72, i_format(12'd3, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        place_step(76, b_format(13'd8, 5'd1, 5'd2, 3'b100), 1'b0, 5'd0, '0, 1'b0);
        place_skipped(80, i_format(12'd4, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        place_step(84, b_format(13'd8, 5'd1, 5'd2, 3'b111), 1'b0, 5'd0, '0, 1'b0);
        place_skipped(88, i_format(12'd5, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        // rdinstret after 18 retired instructions
        place_step(92, i_format(12'hc02, 5'd0, 3'b010, 5'd14, OPC_SYSTEM), 1'b1, 5'd14,
                   32'd18, 1'b0);
        place_step(96, i_format(12'hc00, 5'd0, 3'b010, 5'd15, OPC_SYSTEM), 1'b1, 5'd15,
                   '0, 1'b1);
        place_step(100, i_format(12'hc00, 5'd0, 3'b010, 5'd16, OPC_SYSTEM), 1'b1, 5'd16,
                   '0, 1'b1);
        // x10 stays zero when every skipped slot was really skipped
        place_step(104, r_format(7'h00, 5'd0, 5'd10, 3'b000, 5'd17), 1'b1, 5'd17, '0, 1'b0);
        place_skipped(108, 32'h0000_0000);
    endtask

    task automatic check_cycle_read(input word_t value);
        if (cycle_reads == 0) begin
            check_true(value != '0, "first rdcycle read returned zero");
        end else begin
            check_true(value > last_cycle, "rdcycle did not rise between two reads");
        end
        last_cycle = value;
        cycle_reads++;
    endtask

    // control outputs stay low while reset is held
    initial begin
        repeat (2) @(negedge clk);
        while (!rstn) begin
            check_true(!imem_req && !dmem_req && !dmem_we && !retire && !halted,
                       "control output high during reset");
            @(negedge clk);
        end
    end

    // instruction memory
    initial begin
        int    delay;
        word_t addr;
        imem_valid = 1'b0;
        imem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rstn && imem_req) begin
                addr = imem_addr;
                if (fetches == 0) begin
                    check_value("imem_addr", addr, FIRST_FETCH);
                end
                fetches++;
                delay = int'($urandom_range(4, 1));
                repeat (delay) @(posedge clk);
                #1;
                imem_valid = 1'b1;
                imem_rdata = imem[addr[7:2]];
                @(posedge clk);
                #1;
                imem_valid = 1'b0;
            end
        end
    end

    // data memory
    initial begin
        int    delay;
        word_t addr;
        dmem_valid = 1'b0;
        dmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rstn && dmem_req) begin
                addr = dmem_addr;
                if (dmem_we) begin
                    stores++;
                    check_value("dmem_addr", addr, STORE_ADDR);
                    check_value("dmem_wdata", dmem_wdata, STORE_DATA);
                    dmem[addr[9:2]] = dmem_wdata;
                end else begin
                    loads++;
                end
                delay = int'($urandom_range(4, 1));
                repeat (delay) @(posedge clk);
                #1;
                dmem_valid = 1'b1;
                dmem_rdata = dmem[addr[9:2]];
                @(posedge clk);
                #1;
                dmem_valid = 1'b0;
            end
        end
    end

    // trace compare
    always @(negedge clk) begin
        if (rstn && retire) begin
            if (retired >= exp_pc.size()) begin
                check_true(1'b0, "retire beyond the end of the expected trace");
            end else begin
                check_value("retire_pc", retire_pc, exp_pc[retired]);
                check_value("retire_rd_we", word_t'(retire_rd_we), word_t'(exp_we[retired]));
                if (exp_we[retired]) begin
                    check_value("retire_rd", word_t'(retire_rd), word_t'(exp_rd[retired]));
                    if (exp_cycle[retired]) begin
                        check_cycle_read(retire_rd_data);
                    end else begin
                        check_value("retire_rd_data", retire_rd_data, exp_val[retired]);
                    end
                end
            end
            retired++;
        end
        if (rstn && halted) begin
            check_true(!retire, "retire after halt");
            check_true(!imem_req, "instruction fetch after halt");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out: %0d retired, %0d errors", retired, errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rstn = 1'b0;
        fill_memories();
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait (halted);
        // quiet window after the halt
        repeat (20) @(posedge clk);
        check_true(halted, "halted dropped after the halt");
        check_value("retired count", word_t'(retired), word_t'(exp_pc.size()));
        // every retired word plus the final illegal one is fetched once
        check_value("fetch count", word_t'(fetches), word_t'(exp_pc.size() + 1));
        check_value("store count", word_t'(stores), 32'd1);
        check_value("load count", word_t'(loads), 32'd1);
        check_value("rdcycle reads", word_t'(cycle_reads), 32'd2);
        $display("run finished: %0d retired, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    output logic     imem_req,
    output addr_t    imem_addr,
    input  logic     imem_valid,
    input  word_t    imem_rdata,
    output logic     dmem_req,
    output logic     dmem_we,
    output addr_t    dmem_addr,
    output word_t    dmem_wdata,
    input  logic     dmem_valid,
    input  word_t    dmem_rdata,
    output logic     retire,
    output addr_t    retire_pc,
    output logic     retire_rd_we,
    output reg_idx_t retire_rd,
    output word_t    retire_rd_data,
    output logic     halted
);

    word_t      instr;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       alu_src_pc;
    wb_sel_e    wb_sel;
    br_cond_e   br_cond;
    logic       is_load;
    logic       is_store;
    logic       is_jalr;
    logic [1:0] csr_sel;
    logic       illegal;
    word_t      operand_a;
    word_t      operand_b;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       br_taken;
    word_t      counter_value;
    logic       rd_we;

    cpu_control u_control (
        .clk(clk), .rstn(rstn),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_valid(imem_valid), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_valid(dmem_valid), .dmem_rdata(dmem_rdata),
        .retire(retire), .retire_pc(retire_pc), .retire_rd_we(retire_rd_we),
        .halted(halted),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .rd_idx(retire_rd),
        .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc), .wb_sel(wb_sel),
        .br_cond(br_cond), .is_load(is_load), .is_store(is_store),
        .is_jalr(is_jalr), .illegal(illegal),
        .alu_result(alu_result), .br_taken(br_taken), .counter_value(counter_value),
        .instr(instr), .operand_a(operand_a), .operand_b(operand_b),
        .alu_a(alu_a), .alu_b(alu_b), .rd_we(rd_we), .rd_data(retire_rd_data)
    );

    decoder u_decoder (
        .instr(instr), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(retire_rd),
        .imm(imm), .alu_op(alu_op), .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc),
        .wb_sel(wb_sel), .br_cond(br_cond), .is_load(is_load), .is_store(is_store),
        .is_jalr(is_jalr), .csr_sel(csr_sel), .illegal(illegal)
    );

    reg_file u_reg_file (
        .clk(clk), .rstn(rstn),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(rd_we), .rd_idx(retire_rd), .rd_data(retire_rd_data)
    );

    alu u_alu (
        .alu_op(alu_op), .br_cond(br_cond), .a(alu_a), .b(alu_b),
        .cmp_a(operand_a), .cmp_b(operand_b), .result(alu_result), .br_taken(br_taken)
    );

    perf_counters u_perf_counters (
        .clk(clk), .rstn(rstn), .retire_pulse(retire),
        .csr_sel(csr_sel), .counter_value(counter_value)
    );

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_control import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    output logic     imem_req,
    output addr_t    imem_addr,
    input  logic     imem_valid,
    input  word_t    imem_rdata,
    output logic     dmem_req,
    output logic     dmem_we,
    output addr_t    dmem_addr,
    output word_t    dmem_wdata,
    input  logic     dmem_valid,
    input  word_t    dmem_rdata,
    output logic     retire,
    output addr_t    retire_pc,
    output logic     retire_rd_we,
    output logic     halted,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    imm,
    input  reg_idx_t rd_idx,
    input  logic     alu_src_imm,
    input  logic     alu_src_pc,
    input  wb_sel_e  wb_sel,
    input  br_cond_e br_cond,
    input  logic     is_load,
    input  logic     is_store,
    input  logic     is_jalr,
    input  logic     illegal,
    input  word_t    alu_result,
    input  logic     br_taken,
    input  word_t    counter_value,
    output word_t    instr,
    output word_t    operand_a,
    output word_t    operand_b,
    output word_t    alu_a,
    output word_t    alu_b,
    output logic     rd_we,
    output word_t    rd_data
);

    cpu_state_e state;
    addr_t      pc;
    addr_t      pc_plus4;
    addr_t      target;
    addr_t      next_pc;
    word_t      result_q;
    word_t      mem_q;
    logic       wr_en;

    assign pc_plus4 = pc + 32'd4;
    assign alu_a    = alu_src_pc ? pc : operand_a;
    assign alu_b    = alu_src_imm ? imm : operand_b;

    // jalr clears bit 0, branches and jal add the immediate to pc
    always_comb begin
        if (is_jalr) begin
            target = {alu_result[31:1], 1'b0};
        end else if (br_taken) begin
            target = pc + imm;
        end else begin
            target = pc_plus4;
        end
    end

    // stores and conditional branches leave rd alone
    assign wr_en = !is_store && (br_cond == BR_NEVER || br_cond == BR_ALWAYS);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_FETCH;
            pc       <= `CPU_RESET_PC;
            imem_req <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    imem_req <= 1'b1;
                    state    <= ST_FETCH_WAIT;
                end
                ST_FETCH_WAIT: begin
                    imem_req <= 1'b0;
                    if (imem_valid) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: state <= illegal ? ST_HALT : ST_EXECUTE;
                ST_EXECUTE: state <= (is_load || is_store) ? ST_MEM_WAIT : ST_WRITE;
                ST_MEM_WAIT: begin
                    if (dmem_valid) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    pc    <= next_pc;
                    state <= ST_FETCH;
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    // stage registers
    always_ff @(posedge clk) begin
        if (state == ST_FETCH_WAIT && imem_valid) begin
            instr <= imem_rdata;
        end
        if (state == ST_DECODE) begin
            operand_a <= rs1_data;
            operand_b <= rs2_data;
        end
        if (state == ST_EXECUTE) begin
            result_q <= (wb_sel == WB_CSR) ? counter_value : alu_result;
            next_pc  <= target;
        end
        if (state == ST_MEM_WAIT && dmem_valid) begin
            mem_q <= dmem_rdata;
        end
    end

    assign imem_addr  = pc;
    assign dmem_req   = (state == ST_EXECUTE) && (is_load || is_store);
    assign dmem_we    = dmem_req && is_store;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = operand_b;

    always_comb begin
        case (wb_sel)
            WB_MEM:  rd_data = mem_q;
            WB_PC4:  rd_data = pc_plus4;
            default: rd_data = result_q;
        endcase
    end

    assign retire       = (state == ST_WRITE);
    assign retire_pc    = pc;
    assign retire_rd_we = wr_en && (rd_idx != '0);
    assign rd_we        = retire && retire_rd_we;
    assign halted       = (state == ST_HALT);

endmodule

`default_nettype wire

/* hw/perf_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module perf_counters import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       retire_pulse,
    input  logic [1:0] csr_sel,
    output word_t      counter_value
);

    logic [63:0] cycle_cnt;
    logic [63:0] instret_cnt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
            if (retire_pulse) begin
                instret_cnt <= instret_cnt + 64'd1;
            end
        end
    end

    // sel[1] picks instret, sel[0] the upper half
    always_comb begin
        case (csr_sel)
            2'b00:   counter_value = cycle_cnt[31:0];
            2'b01:   counter_value = cycle_cnt[63:32];
            2'b10:   counter_value = instret_cnt[31:0];
            default: counter_value = instret_cnt[63:32];
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e  alu_op,
    input  br_cond_e br_cond,
    input  word_t    a,
    input  word_t    b,
    input  word_t    cmp_a,
    input  word_t    cmp_b,
    output word_t    result,
    output logic     br_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = word_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // compares always on the register operands
    always_comb begin
        case (br_cond)
            BR_BEQ:    br_taken = (cmp_a == cmp_b);
            BR_BNE:    br_taken = (cmp_a != cmp_b);
            BR_BLT:    br_taken = ($signed(cmp_a) < $signed(cmp_b));
            BR_BGE:    br_taken = ($signed(cmp_a) >= $signed(cmp_b));
            BR_BLTU:   br_taken = (cmp_a < cmp_b);
            BR_BGEU:   br_taken = (cmp_a >= cmp_b);
            BR_ALWAYS: br_taken = 1'b1;
            default:   br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  word_t      instr,
    output reg_idx_t   rs1_idx,
    output reg_idx_t   rs2_idx,
    output reg_idx_t   rd_idx,
    output word_t      imm,
    output alu_op_e    alu_op,
    output logic       alu_src_imm,
    output logic       alu_src_pc,
    output wb_sel_e    wb_sel,
    output br_cond_e   br_cond,
    output logic       is_load,
    output logic       is_store,
    output logic       is_jalr,
    output logic [1:0] csr_sel,
    output logic       illegal
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd_idx  = instr[11:7];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    // csr address bits 1 and 7 pick instret and the high half
    assign csr_sel = {instr[21], instr[27]};

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm         = '0;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b0;
        wb_sel      = WB_ALU;
        br_cond     = BR_NEVER;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_jalr     = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            OPC_LUI: begin
                imm    = imm_u;
                alu_op = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                imm        = imm_u;
                alu_src_pc = 1'b1;
            end
            OPC_JAL: begin
                imm     = imm_j;
                br_cond = BR_ALWAYS;
                wb_sel  = WB_PC4;
            end
            OPC_JALR: begin
                imm     = imm_i;
                is_jalr = 1'b1;
                wb_sel  = WB_PC4;
                illegal = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm         = imm_b;
                alu_src_imm = 1'b0;
                br_cond     = br_cond_e'(funct3);
                illegal     = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD: begin
                imm     = imm_i;
                is_load = 1'b1;
                wb_sel  = WB_MEM;
                illegal = (funct3 != 3'b010);
            end
            OPC_STORE: begin
                imm      = imm_s;
                is_store = 1'b1;
                illegal  = (funct3 != 3'b010);
            end
            OPC_OP_IMM: begin
                imm    = imm_i;
                // only the right shift uses bit 30 as an opcode bit
                alu_op = alu_op_e'({(funct3 == 3'b101) && instr[30], funct3});
                if (funct3 == 3'b001 && funct7 != 7'b0) begin
                    illegal = 1'b1;
                end
                if (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != F7_ALT) begin
                    illegal = 1'b1;
                end
            end
            OPC_OP: begin
                alu_src_imm = 1'b0;
                alu_op      = alu_op_e'({instr[30], funct3});
                illegal     = !((funct7 == 7'b0) ||
                                (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_SYSTEM: begin
                // rdcycle/rdinstret family, csrrs with rs1 = x0
                wb_sel  = WB_CSR;
                illegal = !(funct3 == 3'b010 && rs1_idx == '0 &&
                            (instr[31:20] & ~12'h082) == 12'hC00);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd_idx,
    input  word_t    rd_data
);

    localparam int DEPTH = 2 ** `CPU_REG_AW;

    word_t regs [DEPTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_XLEN-1:0]   addr_t;
    typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM_WAIT,
        ST_WRITE,
        ST_HALT
    } cpu_state_e;

    // encoded as {funct7[5], funct3} so the decoder can cast directly
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_SUB    = 4'b1000,
        ALU_SRA    = 4'b1101,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_CSR
    } wb_sel_e;

    // branch funct3 values, the two unused codes mark never and always
    typedef enum logic [2:0] {
        BR_BEQ    = 3'b000,
        BR_BNE    = 3'b001,
        BR_NEVER  = 3'b010,
        BR_ALWAYS = 3'b011,
        BR_BLT    = 3'b100,
        BR_BGE    = 3'b101,
        BR_BLTU   = 3'b110,
        BR_BGEU   = 3'b111
    } br_cond_e;

endpackage

`default_nettype wire

/* hw/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path width
`define CPU_XLEN 32

// register index width, 32 architectural registers
`define CPU_REG_AW 5

// address of the first instruction fetched after reset
`define CPU_RESET_PC 32'h0000_0000

`endif
